// File: build.f
logic/u2_pkg.sv
logic/wb_slave_decode.sv
logic/settings_bus.sv
logic/control_regs.sv
logic/simple_timer.sv
logic/irq_controller.sv
logic/status_readback.sv
logic/u2_core.sv
tests/u2_core_assertions.sv
tests/tb_u2_core.sv

// File: logic/control_regs.sv
/* Settings registers for the clock, SERDES, ADC, PHY reset and LED outputs;
   each LED is driven by hardware status or software as its source bit says */
`timescale 1ns/1ps
`default_nettype none

module control_regs (
   input  wire                   wb_clk,
   input  wire                   wb_rst,
   input  wire                   set_stb_i,
   input  wire u2_pkg::set_addr_t set_addr_i,
   input  wire u2_pkg::wb_dat_t   set_data_i,
   input  wire                   clk_status_i,
   input  wire                   serdes_link_up_i,
   output logic                  clock_ready_o,
   output logic [1:0]            clk_en_o,
   output logic [1:0]            clk_sel_o,
   output logic                  ser_enable_o,
   output logic                  ser_prbsen_o,
   output logic                  ser_loopen_o,
   output logic                  ser_rx_en_o,
   output logic                  adc_oe_a_o,
   output logic                  adc_on_a_o,
   output logic                  adc_oe_b_o,
   output logic                  adc_on_b_o,
   output logic                  phy_resetn_o,
   output logic [7:0]            leds_o
);
   import u2_pkg::*;

   logic [4:0] clk_reg;
   logic [3:0] ser_reg;
   logic [3:0] adc_reg;
   logic       phy_reset;
   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic [7:0] led_hw;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         clk_reg   <= '0;
         ser_reg   <= '0;
         adc_reg   <= '0;
         phy_reset <= 1'b0;
         led_sw    <= '0;
         led_src   <= LED_SRC_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            SR_CLK:     clk_reg   <= set_data_i[4:0];
            SR_SER:     ser_reg   <= set_data_i[3:0];
            SR_ADC:     adc_reg   <= set_data_i[3:0];
            SR_LED:     led_sw    <= set_data_i[7:0];
            SR_PHY:     phy_reset <= set_data_i[0];
            SR_LED_SRC: led_src   <= set_data_i[7:0];
            default:    ;
         endcase
      end
   end

   ////////////////////////////////////////
   // Board control outputs
   assign {clock_ready_o, clk_en_o, clk_sel_o} = clk_reg;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = ser_reg;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_reg;
   // PHY reset pin is active low
   assign phy_resetn_o = ~phy_reset;

   ////////////////////////////////////////
   // LEDs, source bit 1 selects hardware
   assign led_hw = {5'd0, clk_status_i, serdes_link_up_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

`default_nettype wire

// File: logic/irq_controller.sv
/* Wishbone interrupt controller: rising source edges set pending bits,
   irq_o is the registered OR of pending and mask */
`timescale 1ns/1ps
`default_nettype none

module irq_controller (
   input  wire                   wb_clk,
   input  wire                   wb_rst,
   input  wire                   wb_stb_i,
   input  wire                   wb_we_i,
   input  wire u2_pkg::wb_adr_t   wb_adr_i,
   input  wire u2_pkg::wb_dat_t   wb_dat_i,
   output u2_pkg::wb_dat_t       wb_dat_o,
   output logic                  wb_ack_o,
   input  wire u2_pkg::irq_vec_t  irq_vec_i,
   output logic                  irq_o
);
   import u2_pkg::*;

   irq_vec_t   mask;
   irq_vec_t   pending;
   irq_vec_t   vec_d;
   irq_vec_t   edges;
   irq_vec_t   clr;
   logic [2:0] word;
   logic       wr;

   assign word = wb_adr_i[4:2];
   // Write acts once, on the first cycle of the request
   assign wr = wb_stb_i & ~wb_ack_o & wb_we_i;

   assign edges = irq_vec_i & ~vec_d;
   // Write 1 to clear on the pending word
   assign clr = (wr && word == 3'd1) ? wb_dat_i : '0;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         wb_ack_o <= 1'b0;
         mask     <= '0;
         pending  <= '0;
         vec_d    <= '0;
         irq_o    <= 1'b0;
      end else begin
         wb_ack_o <= wb_stb_i & ~wb_ack_o;
         vec_d    <= irq_vec_i;
         // A new edge wins over a clear in the same cycle
         pending  <= (pending & ~clr) | edges;
         irq_o    <= |(pending & mask);
         if (wr && word == 3'd0) begin
            mask <= wb_dat_i;
         end
      end
   end

   ////////////////////////////////////////
   // Read words
   always_comb begin
      case (word)
         3'd0:    wb_dat_o = mask;
         3'd1:    wb_dat_o = pending;
         3'd2:    wb_dat_o = irq_vec_i;
         default: wb_dat_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: logic/settings_bus.sv
/* Wishbone slave that turns each write into a one-cycle settings strobe
   with word address and data; reads are acked and return nothing */
`timescale 1ns/1ps
`default_nettype none

module settings_bus (
   input  wire                 wb_clk,
   input  wire                 wb_rst,
   input  wire                 wb_stb_i,
   input  wire                 wb_we_i,
   input  wire u2_pkg::wb_adr_t wb_adr_i,
   input  wire u2_pkg::wb_dat_t wb_dat_i,
   output logic                wb_ack_o,
   output logic                set_stb_o,
   output u2_pkg::set_addr_t   set_addr_o,
   output u2_pkg::wb_dat_t     set_data_o
);

   logic first;

   // First cycle of a request, the ack closes it on the next edge
   assign first = wb_stb_i & ~wb_ack_o;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         wb_ack_o  <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         wb_ack_o  <= first;
         set_stb_o <= first & wb_we_i;
      end
   end

   // Word address is byte address bits 9:2
   always_ff @(posedge wb_clk) begin
      if (first) begin
         set_addr_o <= wb_adr_i[9:2];
         set_data_o <= wb_dat_i;
      end
   end

endmodule

`default_nettype wire

// File: logic/simple_timer.sv
/* One-shot and periodic interrupt timer programmed over the settings bus;
   a write of 0 to either word stops that timer */
`timescale 1ns/1ps
`default_nettype none

module simple_timer (
   input  wire                   wb_clk,
   input  wire                   wb_rst,
   input  wire                   set_stb_i,
   input  wire u2_pkg::set_addr_t set_addr_i,
   input  wire u2_pkg::wb_dat_t   set_data_i,
   output logic                  onetime_int_o,
   output logic                  periodic_int_o
);
   import u2_pkg::*;

   localparam set_addr_t SR_PERIODIC = SR_SIMTIMER + 8'd1;

   wb_dat_t onetime_cnt;
   wb_dat_t periodic_cnt;
   wb_dat_t period;
   logic    onetime_wr;
   logic    periodic_wr;

   assign onetime_wr  = set_stb_i & (set_addr_i == SR_SIMTIMER);
   assign periodic_wr = set_stb_i & (set_addr_i == SR_PERIODIC);

   // Down-counter, pulse when it passes from 1 to 0
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         onetime_cnt   <= '0;
         onetime_int_o <= 1'b0;
      end else if (onetime_wr) begin
         onetime_cnt   <= set_data_i;
         onetime_int_o <= 1'b0;
      end else begin
         onetime_int_o <= (onetime_cnt == 32'd1);
         if (onetime_cnt != '0) begin
            onetime_cnt <= onetime_cnt - 32'd1;
         end
      end
   end

   // Reloads from period on every pulse
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         period         <= '0;
         periodic_cnt   <= '0;
         periodic_int_o <= 1'b0;
      end else if (periodic_wr) begin
         period         <= set_data_i;
         periodic_cnt   <= set_data_i;
         periodic_int_o <= 1'b0;
      end else if (period == '0) begin
         periodic_int_o <= 1'b0;
      end else if (periodic_cnt == 32'd1) begin
         periodic_int_o <= 1'b1;
         periodic_cnt   <= period;
      end else begin
         periodic_int_o <= 1'b0;
         periodic_cnt   <= periodic_cnt - 32'd1;
      end
   end

endmodule

`default_nettype wire

// File: logic/status_readback.sv
/* Read-only Wishbone status words: board straps, compatibility number,
   raw interrupt vector and a free-running cycle counter */
`timescale 1ns/1ps
`default_nettype none

module status_readback (
   input  wire                   wb_clk,
   input  wire                   wb_rst,
   input  wire                   wb_stb_i,
   input  wire u2_pkg::wb_adr_t   wb_adr_i,
   output u2_pkg::wb_dat_t       wb_dat_o,
   output logic                  wb_ack_o,
   input  wire u2_pkg::irq_vec_t  irq_vec_i,
   input  wire                   sim_mode_i,
   input  wire [3:0]             clock_divider_i
);
   import u2_pkg::*;

   wb_dat_t cycle_count;
   wb_dat_t word_dat;
   logic    first;

   assign first = wb_stb_i & ~wb_ack_o;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         cycle_count <= '0;
         wb_ack_o    <= 1'b0;
      end else begin
         cycle_count <= cycle_count + 32'd1;
         wb_ack_o    <= first;
      end
   end

   // Sixteen words, unlisted ones read 0
   always_comb begin
      case (wb_adr_i[5:2])
         4'd9:    word_dat = {sim_mode_i, 27'd0, clock_divider_i};
         4'd12:   word_dat = COMPAT_NUM;
         4'd13:   word_dat = irq_vec_i;
         4'd15:   word_dat = cycle_count;
         default: word_dat = '0;
      endcase
   end

   // Sampled together with the ack, writes are ignored
   always_ff @(posedge wb_clk) begin
      if (first) begin
         wb_dat_o <= word_dat;
      end
   end

endmodule

`default_nettype wire

// File: logic/u2_core.sv
/* Top level of the wb_clk control subsystem: address decoder, settings bus
   with its control registers and timer, interrupt controller and status words */
`timescale 1ns/1ps
`default_nettype none

module u2_core (
   input  wire                 wb_clk,
   input  wire                 wb_rst,
   input  wire u2_pkg::wb_adr_t wb_adr_i,
   input  wire u2_pkg::wb_dat_t wb_dat_i,
   input  wire u2_pkg::wb_sel_t wb_sel_i,
   input  wire                 wb_we_i,
   input  wire                 wb_cyc_i,
   input  wire                 wb_stb_i,
   output u2_pkg::wb_dat_t     wb_dat_o,
   output logic                wb_ack_o,
   output logic                wb_err_o,
   input  wire                 phy_int_n_i,
   input  wire                 clk_status_i,
   input  wire                 serdes_link_up_i,
   input  wire                 sim_mode_i,
   input  wire [3:0]           clock_divider_i,
   output logic                irq_o,
   output logic                clock_ready_o,
   output logic [1:0]          clk_en_o,
   output logic [1:0]          clk_sel_o,
   output logic                ser_enable_o,
   output logic                ser_prbsen_o,
   output logic                ser_loopen_o,
   output logic                ser_rx_en_o,
   output logic                adc_oe_a_o,
   output logic                adc_on_a_o,
   output logic                adc_oe_b_o,
   output logic                adc_on_b_o,
   output logic                phy_resetn_o,
   output logic [7:0]          leds_o
);
   import u2_pkg::*;

   logic      rb_stb, set_wb_stb, pic_stb;
   logic      rb_ack, set_ack, pic_ack;
   wb_dat_t   rb_dat, pic_dat;
   logic      set_stb;
   set_addr_t set_addr;
   wb_dat_t   set_data;
   logic      onetime_int, periodic_int;
   irq_vec_t  irq_vec;

   ////////////////////////////////////////
   // Bus decode
   wb_slave_decode slave_decode_inst (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_adr_i(wb_adr_i), .wb_sel_i(wb_sel_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
      .rb_stb_o(rb_stb), .set_wb_stb_o(set_wb_stb), .pic_stb_o(pic_stb),
      .rb_ack_i(rb_ack), .rb_dat_i(rb_dat), .set_ack_i(set_ack),
      .pic_ack_i(pic_ack), .pic_dat_i(pic_dat),
      .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o), .wb_dat_o(wb_dat_o));

   ////////////////////////////////////////
   // Settings bus and its registers
   settings_bus settings_bus_inst (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_stb_i(set_wb_stb), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
      .wb_ack_o(set_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   control_regs control_regs_inst (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_resetn_o(phy_resetn_o), .leds_o(leds_o));

   simple_timer simple_timer_inst (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .onetime_int_o(onetime_int), .periodic_int_o(periodic_int));

   // Interrupt sources, PHY line is active low
   always_comb begin
      irq_vec                 = '0;
      irq_vec[IRQ_ONETIME]    = onetime_int;
      irq_vec[IRQ_PHY]        = ~phy_int_n_i;
      irq_vec[IRQ_PERIODIC]   = periodic_int;
      irq_vec[IRQ_CLK_STATUS] = clk_status_i;
   end

   irq_controller irq_controller_inst (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_stb_i(pic_stb), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
      .wb_dat_o(pic_dat), .wb_ack_o(pic_ack),
      .irq_vec_i(irq_vec), .irq_o(irq_o));

   status_readback status_readback_inst (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_stb_i(rb_stb), .wb_adr_i(wb_adr_i), .wb_dat_o(rb_dat), .wb_ack_o(rb_ack),
      .irq_vec_i(irq_vec), .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i));

endmodule

`default_nettype wire

// File: logic/u2_pkg.sv
/* Bus types, address map, settings register numbers and reset values
   of the Wishbone control subsystem, shared by all of its modules */
`default_nettype none

package u2_pkg;

   ////////////////////////////////////////
   // Bus and vector types
   typedef logic [15:0] wb_adr_t;
   typedef logic [31:0] wb_dat_t;
   typedef logic [3:0]  wb_sel_t;
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] irq_vec_t;

   ////////////////////////////////////////
   // Address map, top address bits per slot
   localparam int DECODE_W = 6;

   // 0xCC00
   localparam logic [DECODE_W-1:0] SLOT_READBACK = 6'b110011;
   // 0xD400
   localparam logic [DECODE_W-1:0] SLOT_SETTINGS = 6'b110101;
   // 0xD800
   localparam logic [DECODE_W-1:0] SLOT_PIC      = 6'b110110;

   ////////////////////////////////////////
   // Settings bus word addresses
   localparam set_addr_t SR_CLK      = 8'd0;
   localparam set_addr_t SR_SER      = 8'd1;
   localparam set_addr_t SR_ADC      = 8'd2;
   localparam set_addr_t SR_LED      = 8'd3;
   localparam set_addr_t SR_PHY      = 8'd4;
   localparam set_addr_t SR_LED_SRC  = 8'd8;
   // Timer takes this word and the next one
   localparam set_addr_t SR_SIMTIMER = 8'd198;

   // LEDs 1 to 4 on hardware after reset
   localparam logic [7:0] LED_SRC_RESET = 8'h1E;

   // Bump when the register map changes
   localparam wb_dat_t COMPAT_NUM = 32'd4;

   // Interrupt vector bit positions
   localparam int IRQ_ONETIME    = 1;
   localparam int IRQ_PHY        = 4;
   localparam int IRQ_PERIODIC   = 12;
   localparam int IRQ_CLK_STATUS = 13;

endpackage

`default_nettype wire

// File: logic/wb_slave_decode.sv
/* Address decoder between the external Wishbone master and the three slaves;
   unmapped slots and empty byte selects get a registered error */
`timescale 1ns/1ps
`default_nettype none

module wb_slave_decode (
   input  wire                 wb_clk,
   input  wire                 wb_rst,
   input  wire u2_pkg::wb_adr_t wb_adr_i,
   input  wire u2_pkg::wb_sel_t wb_sel_i,
   input  wire                 wb_cyc_i,
   input  wire                 wb_stb_i,
   output logic                rb_stb_o,
   output logic                set_wb_stb_o,
   output logic                pic_stb_o,
   input  wire                 rb_ack_i,
   input  wire u2_pkg::wb_dat_t rb_dat_i,
   input  wire                 set_ack_i,
   input  wire                 pic_ack_i,
   input  wire u2_pkg::wb_dat_t pic_dat_i,
   output logic                wb_ack_o,
   output logic                wb_err_o,
   output u2_pkg::wb_dat_t     wb_dat_o
);
   import u2_pkg::*;

   logic [DECODE_W-1:0] slot;
   logic                req;
   logic                lanes;
   logic                hit_rb;
   logic                hit_set;
   logic                hit_pic;

   assign slot  = wb_adr_i[$bits(wb_adr_t)-1 -: DECODE_W];
   assign req   = wb_cyc_i & wb_stb_i;
   // No byte lane selected counts as a miss
   assign lanes = |wb_sel_i;

   assign hit_rb  = lanes & (slot == SLOT_READBACK);
   assign hit_set = lanes & (slot == SLOT_SETTINGS);
   assign hit_pic = lanes & (slot == SLOT_PIC);

   assign rb_stb_o     = req & hit_rb;
   assign set_wb_stb_o = req & hit_set;
   assign pic_stb_o    = req & hit_pic;

   // Return path from the selected slave, settings slot reads zero
   always_comb begin
      wb_ack_o = 1'b0;
      wb_dat_o = '0;
      if (hit_rb) begin
         wb_ack_o = rb_ack_i;
         wb_dat_o = rb_dat_i;
      end else if (hit_set) begin
         wb_ack_o = set_ack_i;
      end else if (hit_pic) begin
         wb_ack_o = pic_ack_i;
         wb_dat_o = pic_dat_i;
      end
   end

   // Error one cycle after stb, single cycle wide
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         wb_err_o <= 1'b0;
      end else begin
         wb_err_o <= req & ~(hit_rb | hit_set | hit_pic) & ~wb_err_o;
      end
   end

endmodule

`default_nettype wire

// File: tests/tb_u2_core.sv
/* Testbench for the control subsystem. A Wishbone master drives settings,
   LEDs, status words, timer and PHY interrupts and the empty address slots */
`timescale 1ns/1ps
`default_nettype none

module tb_u2_core;
   import u2_pkg::*;

   // Run limit in clock cycles
   localparam int TIMEOUT_CYCLES = 2000;
   localparam wb_adr_t RB_BASE  = {SLOT_READBACK, 10'd0};
   localparam wb_adr_t SET_BASE = {SLOT_SETTINGS, 10'd0};
   localparam wb_adr_t PIC_BASE = {SLOT_PIC, 10'd0};

   logic       wb_clk;
   logic       wb_rst;
   wb_adr_t    wb_adr;
   wb_dat_t    wb_dat_w;
   wb_dat_t    wb_dat_r;
   wb_sel_t    wb_sel;
   logic       wb_we, wb_cyc, wb_stb;
   logic       wb_ack, wb_err;
   logic       phy_int_n, clk_status, serdes_link_up, sim_mode;
   logic [3:0] clock_divider;
   logic       irq, clock_ready, phy_resetn;
   logic [1:0] clk_en, clk_sel;
   logic       ser_enable, ser_prbsen, ser_loopen, ser_rx_en;
   logic       adc_oe_a, adc_on_a, adc_oe_b, adc_on_b;
   logic [7:0] leds;
   int         run_cycles;
   integer     seed;

   u2_core u2_core_inst (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_sel_i(wb_sel), .wb_we_i(wb_we),
      .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
      .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack), .wb_err_o(wb_err),
      .phy_int_n_i(phy_int_n), .clk_status_i(clk_status), .serdes_link_up_i(serdes_link_up),
      .sim_mode_i(sim_mode), .clock_divider_i(clock_divider),
      .irq_o(irq), .clock_ready_o(clock_ready), .clk_en_o(clk_en), .clk_sel_o(clk_sel),
      .ser_enable_o(ser_enable), .ser_prbsen_o(ser_prbsen),
      .ser_loopen_o(ser_loopen), .ser_rx_en_o(ser_rx_en),
      .adc_oe_a_o(adc_oe_a), .adc_on_a_o(adc_on_a),
      .adc_oe_b_o(adc_oe_b), .adc_on_b_o(adc_on_b),
      .phy_resetn_o(phy_resetn), .leds_o(leds));

   initial begin
      wb_clk = 1'b0;
      forever #10 wb_clk = ~wb_clk;
   end

   initial begin
      run_cycles = 0;
      while (run_cycles < TIMEOUT_CYCLES) begin
         @(posedge wb_clk);
         run_cycles++;
      end
      $display("Errors found");
      $fatal(1, "Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
   end

   initial begin
      wait (u2_core_inst.u2_core_assertions_inst.fail_count != 0);
      $display("Errors found");
      $fatal(1, "A bound assertion on the DUT ports failed");
   end

   ////////////////////////////////////////
   // Helpers

   // Inputs change 1 ns after the rising edge
   task automatic next_edge();
      @(posedge wb_clk);
      #1;
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else begin
         $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
         $display("Errors found");
         $fatal(1, "Value mismatch in %s", name);
      end
   endtask

   task automatic bus_cycle(input wb_adr_t adr, input logic we, input wb_dat_t wdat,
                            output wb_dat_t rdat, output logic err);
      next_edge();
      wb_adr   = adr;
      wb_dat_w = wdat;
      wb_we    = we;
      wb_sel   = 4'hF;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      // Hold the request until ack or err
      do begin
         next_edge();
      end while (!wb_ack && !wb_err);
      rdat   = wb_dat_r;
      err    = wb_err;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic bus_write(input wb_adr_t adr, input wb_dat_t wdat);
      wb_dat_t rdat;
      logic    err;
      bus_cycle(adr, 1'b1, wdat, rdat, err);
      check_value("write response", 32'd0, 32'(err));
   endtask

   task automatic bus_read(input wb_adr_t adr, output wb_dat_t rdat);
      logic err;
      bus_cycle(adr, 1'b0, 32'd0, rdat, err);
      check_value("read response", 32'd0, 32'(err));
   endtask

   function automatic wb_adr_t word_adr(input wb_adr_t base, input int word);
      return base + wb_adr_t'(word * 4);
   endfunction

   task automatic set_write(input set_addr_t addr, input wb_dat_t wdat);
      bus_write(word_adr(SET_BASE, int'(addr)), wdat);
   endtask

   // Each LED takes hardware where its source bit is 1 and software where it is 0
   function automatic logic [7:0] led_expect(input logic [7:0] src, input logic [7:0] sw,
                                             input logic link, input logic status);
      logic [7:0] hw;
      logic [7:0] led;
      hw    = 8'd0;
      hw[1] = link;
      hw[2] = status;
      for (int i = 0; i < 8; i++) begin
         led[i] = src[i] ? hw[i] : sw[i];
      end
      return led;
   endfunction

   function automatic logic [31:0] outputs_state();
      return {9'd0, irq, clock_ready, clk_en, clk_sel, ser_enable, ser_prbsen, ser_loopen,
              ser_rx_en, adc_oe_a, adc_on_a, adc_oe_b, adc_on_b, phy_resetn, leds};
   endfunction

   ////////////////////////////////////////
   // Stimulus
   initial begin
      wb_dat_t     rdat;
      wb_dat_t     val;
      wb_dat_t     c1;
      wb_dat_t     straps;
      logic [31:0] snap;
      logic [7:0]  sw;
      logic [7:0]  src;
      logic        err;
      int          n;
      int          t1;
      seed           = 32'h57d4c44e;
      wb_rst         = 1'b1;
      wb_adr         = '0;
      wb_dat_w       = '0;
      wb_sel         = '0;
      wb_we          = 1'b0;
      wb_cyc         = 1'b0;
      wb_stb         = 1'b0;
      phy_int_n      = 1'b1;
      clk_status     = 1'b0;
      serdes_link_up = 1'b0;
      sim_mode       = 1'b0;
      clock_divider  = 4'd0;
      repeat (10) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;

      // LEDs show only hardware bits with the reset source
      for (int i = 0; i < 4; i++) begin
         clk_status     = i[1];
         serdes_link_up = i[0];
         next_edge();
         check_value("leds reset source", 32'(led_expect(LED_SRC_RESET, 8'd0, i[0], i[1])),
                     32'(leds));
      end

      // Settings outputs follow two edges after stb
      for (int i = 0; i < 8; i++) begin
         val = $random(seed);
         set_write(SR_CLK, val);
         next_edge();
         check_value("settings clk", 32'(val[4:0]), 32'({clock_ready, clk_en, clk_sel}));
         val = $random(seed);
         set_write(SR_SER, val);
         next_edge();
         check_value("settings ser", 32'(val[3:0]),
                     32'({ser_enable, ser_prbsen, ser_loopen, ser_rx_en}));
         val = $random(seed);
         set_write(SR_ADC, val);
         next_edge();
         check_value("settings adc", 32'(val[3:0]),
                     32'({adc_oe_a, adc_on_a, adc_oe_b, adc_on_b}));
         val = $random(seed);
         set_write(SR_PHY, val);
         next_edge();
         check_value("settings phy", 32'(!val[0]), 32'(phy_resetn));
      end

      // LEDs with random source and software values
      for (int i = 0; i < 4; i++) begin
         val            = $random(seed);
         sw             = val[7:0];
         src            = val[15:8];
         clk_status     = val[16];
         serdes_link_up = val[17];
         set_write(SR_LED, 32'(sw));
         set_write(SR_LED_SRC, 32'(src));
         next_edge();
         check_value("leds mixed", 32'(led_expect(src, sw, serdes_link_up, clk_status)),
                     32'(leds));
      end

      ////////////////////////////////////////
      // Status words
      bus_read(word_adr(RB_BASE, 12), rdat);
      check_value("compat number", COMPAT_NUM, rdat);
      val           = $random(seed);
      sim_mode      = val[31];
      clock_divider = val[3:0];
      bus_read(word_adr(RB_BASE, 9), rdat);
      straps      = '0;
      straps[31]  = sim_mode;
      straps[3:0] = clock_divider;
      check_value("straps word", straps, rdat);
      bus_read(word_adr(RB_BASE, 15), c1);
      t1  = run_cycles;
      val = $random(seed);
      repeat (1 + int'(val[4:0])) next_edge();
      bus_read(word_adr(RB_BASE, 15), rdat);
      check_value("cycle counter", 32'(run_cycles - t1), rdat - c1);

      ////////////////////////////////////////
      // One-shot timer sets pending N+3 edges after stb and irq one edge later
      bus_write(word_adr(PIC_BASE, 1), 32'hFFFF_FFFF);
      bus_write(word_adr(PIC_BASE, 0), 32'd1 << IRQ_ONETIME);
      val = $random(seed);
      n   = 2 + int'(val[3:0]);
      set_write(SR_SIMTIMER, 32'(n));
      repeat (n + 2) next_edge();
      check_value("onetime irq early", 32'd0, 32'(irq));
      next_edge();
      check_value("onetime irq", 32'd1, 32'(irq));
      bus_read(word_adr(PIC_BASE, 1), rdat);
      check_value("onetime pending", 32'd1 << IRQ_ONETIME, rdat);
      bus_write(word_adr(PIC_BASE, 1), 32'd1 << IRQ_ONETIME);
      next_edge();
      check_value("onetime irq cleared", 32'd0, 32'(irq));
      bus_read(word_adr(PIC_BASE, 1), rdat);
      check_value("onetime pending cleared", 32'd0, rdat);

      // Periodic timer fires again after a clear
      bus_write(word_adr(PIC_BASE, 0), 32'd1 << IRQ_PERIODIC);
      val = $random(seed);
      n   = 8 + int'(val[2:0]);
      set_write(SR_SIMTIMER + 8'd1, 32'(n));
      repeat (n + 1) next_edge();
      bus_read(word_adr(PIC_BASE, 1), rdat);
      check_value("periodic pending", 32'd1 << IRQ_PERIODIC, rdat);
      bus_write(word_adr(PIC_BASE, 1), 32'd1 << IRQ_PERIODIC);
      bus_read(word_adr(PIC_BASE, 1), rdat);
      check_value("periodic pending cleared", 32'd0, rdat);
      repeat (n) next_edge();
      bus_read(word_adr(PIC_BASE, 1), rdat);
      check_value("periodic pending again", 32'd1 << IRQ_PERIODIC, rdat);
      check_value("periodic irq", 32'd1, 32'(irq));
      set_write(SR_SIMTIMER + 8'd1, 32'd0);
      bus_write(word_adr(PIC_BASE, 1), 32'hFFFF_FFFF);
      bus_write(word_adr(PIC_BASE, 0), 32'd0);
      next_edge();
      check_value("irq after stop", 32'd0, 32'(irq));

      ////////////////////////////////////////
      // PHY interrupt reaches irq only when unmasked
      phy_int_n = 1'b0;
      repeat (3) next_edge();
      check_value("phy irq masked", 32'd0, 32'(irq));
      bus_read(word_adr(PIC_BASE, 1), rdat);
      check_value("phy pending", 32'd1 << IRQ_PHY, rdat);
      bus_write(word_adr(PIC_BASE, 0), 32'd1 << IRQ_PHY);
      next_edge();
      check_value("phy irq unmasked", 32'd1, 32'(irq));
      phy_int_n = 1'b1;
      bus_write(word_adr(PIC_BASE, 1), 32'd1 << IRQ_PHY);
      next_edge();
      check_value("phy irq cleared", 32'd0, 32'(irq));
      bus_write(word_adr(PIC_BASE, 0), 32'd0);

      ////////////////////////////////////////
      // Empty slots answer with err and zero data
      snap = outputs_state();
      val  = $random(seed);
      bus_cycle(16'h0000, 1'b1, val, rdat, err);
      check_value("empty slot write err", 32'd1, 32'(err));
      bus_cycle(16'hD000, 1'b0, 32'd0, rdat, err);
      check_value("empty slot read err", 32'd1, 32'(err));
      check_value("empty slot read data", 32'd0, rdat);
      repeat (2) next_edge();
      check_value("outputs after empty slot", snap, outputs_state());

      if (u2_core_inst.u2_core_assertions_inst.fail_count == 0) begin
         $display("No errors");
         $finish;
      end else begin
         $display("Errors found");
         $fatal(1, "Bound assertion failures were recorded");
      end
   end

endmodule

`default_nettype wire

// File: tests/u2_core_assertions.sv
/* Concurrent checks on the top-level Wishbone handshake and reset values,
   bound into u2_core */
`timescale 1ns/1ps
`default_nettype none

module u2_core_assertions (
   input wire        wb_clk,
   input wire        wb_rst,
   input wire        wb_stb_i,
   input wire        wb_ack_i,
   input wire        wb_err_i,
   input wire        irq_i,
   input wire [12:0] ctrl_i,
   input wire        phy_resetn_i
);

   int unsigned fail_count = 0;

   // A slave answers with ack or err, never both
   ack_err_exclusive: assert property (@(posedge wb_clk) disable iff (wb_rst)
      !(wb_ack_i && wb_err_i))
      else begin
         $error("ack and err high in the same cycle");
         fail_count++;
      end

   // Responses are single-cycle pulses
   ack_single: assert property (@(posedge wb_clk) disable iff (wb_rst)
      wb_ack_i |=> !wb_ack_i)
      else begin
         $error("ack held for more than one cycle");
         fail_count++;
      end

   err_single: assert property (@(posedge wb_clk) disable iff (wb_rst)
      wb_err_i |=> !wb_err_i)
      else begin
         $error("err held for more than one cycle");
         fail_count++;
      end

   // No response without a request in the cycle before
   resp_after_stb: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (wb_ack_i || wb_err_i) |-> $past(wb_stb_i))
      else begin
         $error("ack or err without stb in the previous cycle");
         fail_count++;
      end

   ////////////////////////////////////////
   // Reset values once reset has been seen at an edge
   reset_values: assert property (@(posedge wb_clk)
      (wb_rst && $past(wb_rst)) |-> (ctrl_i == '0) && phy_resetn_i && !irq_i)
      else begin
         $error("control outputs or irq not at reset value during reset");
         fail_count++;
      end

endmodule

bind u2_core u2_core_assertions u2_core_assertions_inst (
   .wb_clk(wb_clk), .wb_rst(wb_rst), .wb_stb_i(wb_stb_i),
   .wb_ack_i(wb_ack_o), .wb_err_i(wb_err_o), .irq_i(irq_o),
   .ctrl_i({clock_ready_o, clk_en_o, clk_sel_o, ser_enable_o, ser_prbsen_o, ser_loopen_o,
            ser_rx_en_o, adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}),
   .phy_resetn_i(phy_resetn_o));

`default_nettype wire
